// ==== hw/mips_debug_pkg.sv ====
`default_nettype none

package mips_debug_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int WORD_BITS   = 32; // Instruction word.
  localparam int BYTE_BITS   = 8;  // One UART frame.
  localparam int OPCODE_BITS = 6;  // Opcode field at the word top.

  ////////////////////
  // Host commands
  ////////////////////

  typedef enum logic [BYTE_BITS-1:0] {
    CMD_RESET    = 8'h00, // Soft reset and reload.
    CMD_READY    = 8'h01, // Ready byte, both directions.
    CMD_STEP     = 8'h02, // One instruction.
    CMD_RUN      = 8'h03, // Continuous mode.
    CMD_RUN_STEP = 8'h07  // Step mode.
  } cmd_e;

  ////////////////////
  // State machines
  ////////////////////

  typedef enum logic [2:0] {
    IDLE,
    SOFT_RESET,
    WAIT_HOST_ACK,
    LOAD_PROGRAM,
    WAIT_START,
    RUNNING
  } debug_state_e;

  typedef enum logic [1:0] {
    HOLD,
    READ,
    DELIVER,
    STOPPED
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLOCKS_PER_BIT = 16
) (
  input  wire                                  i_clock,
  input  wire                                  i_reset,
  input  wire                                  i_rx,
  output logic [mips_debug_pkg::BYTE_BITS-1:0] o_rx_data,
  output logic                                 o_rx_done
);
  import mips_debug_pkg::*;

  localparam int CNT_BITS = $clog2(CLOCKS_PER_BIT);
  localparam int IDX_BITS = $clog2(BYTE_BITS);
  localparam logic [CNT_BITS-1:0] BIT_END  = CNT_BITS'(CLOCKS_PER_BIT - 1);
  localparam logic [CNT_BITS-1:0] HALF_BIT = CNT_BITS'(CLOCKS_PER_BIT / 2 - 1);
  localparam logic [IDX_BITS-1:0] LAST_BIT = IDX_BITS'(BYTE_BITS - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic [CNT_BITS-1:0]  count;
  logic [IDX_BITS-1:0]  bit_idx;
  logic [BYTE_BITS-1:0] shift;
  logic                 bit_end;

  assign bit_end = (count == BIT_END); // Centre of a data or stop bit.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state     <= RX_IDLE;
      rx_meta   <= 1'b1; // Line idles high.
      rx_sync   <= 1'b1;
      count     <= '0;
      bit_idx   <= '0;
      o_rx_done <= 1'b0;
    end else begin
      rx_meta   <= i_rx;
      rx_sync   <= rx_meta;
      o_rx_done <= 1'b0;
      case (state)
        RX_IDLE: begin
          count <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (rx_sync) begin
            state <= RX_IDLE; // Glitch, not a start bit.
          end else if (count == HALF_BIT) begin
            count   <= '0;
            bit_idx <= '0;
            state   <= RX_DATA;
          end else begin
            count <= count + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            count <= '0;
            if (bit_idx == LAST_BIT) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            count <= count + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            count     <= '0;
            state     <= RX_IDLE;
            o_rx_done <= rx_sync; // Framing error drops the byte.
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge i_clock) begin
    if (state == RX_DATA && bit_end) begin
      shift <= {rx_sync, shift[BYTE_BITS-1:1]};
    end
    if (state == RX_STOP && bit_end && rx_sync) begin
      o_rx_data <= shift;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
  parameter int CLOCKS_PER_BIT = 16
) (
  input  wire                                 i_clock,
  input  wire                                 i_reset,
  input  wire                                 i_tx_start,
  input  wire [mips_debug_pkg::BYTE_BITS-1:0] i_tx_data,
  output logic                                o_tx,
  output logic                                o_tx_done
);
  import mips_debug_pkg::*;

  localparam int CNT_BITS = $clog2(CLOCKS_PER_BIT);
  localparam int IDX_BITS = $clog2(BYTE_BITS);
  localparam logic [CNT_BITS-1:0] BIT_END  = CNT_BITS'(CLOCKS_PER_BIT - 1);
  localparam logic [IDX_BITS-1:0] LAST_BIT = IDX_BITS'(BYTE_BITS - 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e            state;
  logic [CNT_BITS-1:0]  count;
  logic [IDX_BITS-1:0]  bit_idx;
  logic [BYTE_BITS-1:0] shift;
  logic                 bit_end;

  assign bit_end = (count == BIT_END);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state     <= TX_IDLE;
      count     <= '0;
      bit_idx   <= '0;
      o_tx      <= 1'b1;
      o_tx_done <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      case (state)
        TX_IDLE: begin
          count   <= '0;
          bit_idx <= '0;
          if (i_tx_start) begin
            o_tx  <= 1'b0; // Start bit.
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            count <= '0;
            o_tx  <= shift[0];
            state <= TX_DATA;
          end else begin
            count <= count + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            count <= '0;
            if (bit_idx == LAST_BIT) begin
              o_tx  <= 1'b1; // Stop bit.
              state <= TX_STOP;
            end else begin
              o_tx    <= shift[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            count <= count + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            o_tx_done <= 1'b1;
            state     <= TX_IDLE; // Held start sends again.
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clock) begin
    if (state == TX_IDLE && i_tx_start) begin
      shift <= i_tx_data; // Latched for the whole frame.
    end else if ((state == TX_START || state == TX_DATA) && bit_end) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/debug_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module debug_unit #(
  parameter int                                     ADDR_BITS   = 8,
  parameter logic [mips_debug_pkg::OPCODE_BITS-1:0] HALT_OPCODE = 6'b111111
) (
  input  wire                                  i_clock,
  input  wire                                  i_reset,
  input  wire                                  i_rx_done,
  input  wire  [mips_debug_pkg::BYTE_BITS-1:0] i_rx_data,
  input  wire                                  i_tx_done,
  input  wire                                  i_soft_reset_ack,
  output logic                                 o_tx_start,
  output logic [mips_debug_pkg::BYTE_BITS-1:0] o_tx_data,
  output logic                                 o_soft_reset,
  output logic                                 o_mem_write,
  output logic [ADDR_BITS-1:0]                 o_mem_addr,
  output logic [mips_debug_pkg::WORD_BITS-1:0] o_mem_data,
  output logic                                 o_run,
  output logic                                 o_step_mode,
  output logic                                 o_step
);
  import mips_debug_pkg::*;

  localparam int BYTES_PER_WORD = WORD_BITS / BYTE_BITS;
  localparam int COUNT_BITS     = $clog2(BYTES_PER_WORD);
  localparam logic [COUNT_BITS-1:0] LAST_BYTE = COUNT_BITS'(BYTES_PER_WORD - 1);

  debug_state_e          state;
  logic [COUNT_BITS-1:0] byte_count;
  logic [WORD_BITS-1:0]  word;
  logic [WORD_BITS-1:0]  next_word;
  logic                  ready_sent;
  logic                  word_done;
  logic                  halt_word;

  ////////////////////
  // Word assembly
  ////////////////////

  assign next_word = {word[WORD_BITS-BYTE_BITS-1:0], i_rx_data}; // MSB first.
  assign word_done = (state == LOAD_PROGRAM) && i_rx_done && (byte_count == LAST_BYTE);
  assign halt_word = (next_word[WORD_BITS-1 -: OPCODE_BITS] == HALT_OPCODE);

  always_ff @(posedge i_clock) begin
    if (state == LOAD_PROGRAM && i_rx_done) begin
      word <= next_word;
    end
  end

  ////////////////////
  // Outputs by state
  ////////////////////

  assign o_soft_reset = !(state == SOFT_RESET || state == WAIT_HOST_ACK); // Active low.
  assign o_tx_start   = (state == WAIT_HOST_ACK); // Repeats until host answers.
  assign o_tx_data    = CMD_READY;
  assign o_mem_data   = word; // Full word in the write cycle.

  ////////////////////
  // Command FSM
  ////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state       <= IDLE;
      byte_count  <= '0;
      ready_sent  <= 1'b0;
      o_mem_write <= 1'b0;
      o_mem_addr  <= '0;
      o_run       <= 1'b0;
      o_step      <= 1'b0;
      o_step_mode <= 1'b0;
    end else begin
      o_mem_write <= word_done;
      o_run       <= 1'b0;
      o_step      <= 1'b0;
      if (o_mem_write) begin
        o_mem_addr <= o_mem_addr + 1'b1; // Next word address.
      end
      case (state)
        IDLE: begin
          if (i_rx_done && i_rx_data == CMD_RESET) begin
            state <= SOFT_RESET;
          end
        end
        SOFT_RESET: begin
          byte_count  <= '0;
          ready_sent  <= 1'b0;
          o_mem_addr  <= '0;
          o_step_mode <= 1'b0;
          if (i_soft_reset_ack) begin
            state <= WAIT_HOST_ACK;
          end
        end
        WAIT_HOST_ACK: begin
          if (i_tx_done) begin
            ready_sent <= 1'b1; // At least one ready byte is out.
          end
          if (i_rx_done && i_rx_data == CMD_READY && ready_sent) begin
            state <= LOAD_PROGRAM;
          end
        end
        LOAD_PROGRAM: begin
          if (i_rx_done) begin
            byte_count <= byte_count + 1'b1; // Wraps per word.
          end
          if (word_done && halt_word) begin
            state <= WAIT_START; // Halt word is the last one.
          end
        end
        WAIT_START: begin
          if (i_rx_done && (i_rx_data == CMD_RUN || i_rx_data == CMD_RUN_STEP)) begin
            o_run       <= 1'b1;
            o_step_mode <= (i_rx_data == CMD_RUN_STEP);
            state       <= RUNNING;
          end
        end
        RUNNING: begin
          if (i_rx_done && i_rx_data == CMD_STEP) begin
            o_step <= 1'b1;
          end else if (i_rx_done && i_rx_data == CMD_RESET) begin
            state <= SOFT_RESET; // Reload.
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/program_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module program_memory #(
  parameter int ADDR_BITS = 8
) (
  input  wire                                  i_clock,
  input  wire                                  i_write,
  input  wire  [ADDR_BITS-1:0]                 i_write_addr,
  input  wire  [mips_debug_pkg::WORD_BITS-1:0] i_write_data,
  input  wire  [ADDR_BITS-1:0]                 i_read_addr,
  output logic [mips_debug_pkg::WORD_BITS-1:0] o_read_data
);
  import mips_debug_pkg::*;

  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [WORD_BITS-1:0] mem [DEPTH];

  // Block RAM style, one write and one registered read port.
  always_ff @(posedge i_clock) begin
    if (i_write) begin
      mem[i_write_addr] <= i_write_data;
    end
    o_read_data <= mem[i_read_addr];
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
  parameter int                                     ADDR_BITS   = 8,
  parameter logic [mips_debug_pkg::OPCODE_BITS-1:0] HALT_OPCODE = 6'b111111
) (
  input  wire                                  i_clock,
  input  wire                                  i_reset,
  input  wire                                  i_soft_reset,
  input  wire                                  i_run,
  input  wire                                  i_step_mode,
  input  wire                                  i_step,
  input  wire  [mips_debug_pkg::WORD_BITS-1:0] i_read_data,
  output logic                                 o_soft_reset_ack,
  output logic [ADDR_BITS-1:0]                 o_read_addr,
  output logic [mips_debug_pkg::WORD_BITS-1:0] o_instruction,
  output logic [ADDR_BITS-1:0]                 o_pc,
  output logic                                 o_instruction_valid,
  output logic                                 o_halted
);
  import mips_debug_pkg::*;

  fetch_state_e         state;
  logic [ADDR_BITS-1:0] pc;
  logic                 go; // Permission for one fetch in step mode.
  logic                 is_halt;

  assign o_read_addr         = pc;
  assign o_pc                = pc;
  assign o_instruction       = i_read_data; // Valid in DELIVER.
  assign o_instruction_valid = (state == DELIVER);
  assign is_halt = (i_read_data[WORD_BITS-1 -: OPCODE_BITS] == HALT_OPCODE);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state            <= HOLD;
      pc               <= '0;
      go               <= 1'b0;
      o_halted         <= 1'b0;
      o_soft_reset_ack <= 1'b0;
    end else begin
      o_soft_reset_ack <= !i_soft_reset;
      if (!i_soft_reset) begin
        state    <= HOLD;
        pc       <= '0;
        go       <= 1'b0;
        o_halted <= 1'b0;
      end else begin
        if (i_step) begin
          go <= 1'b1;
        end
        case (state)
          HOLD: begin
            if (i_run) begin
              go    <= 1'b1; // First word needs no step.
              state <= READ;
            end
          end
          READ: begin
            if (!i_step_mode || go) begin
              go    <= 1'b0;
              state <= DELIVER;
            end
          end
          DELIVER: begin
            if (is_halt) begin
              o_halted <= 1'b1;
              state    <= STOPPED;
            end else begin
              pc    <= pc + 1'b1;
              state <= READ;
            end
          end
          STOPPED: state <= STOPPED; // Until the next soft reset.
          default: state <= HOLD;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mips_debug_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_debug_top #(
  parameter int                                     ADDR_BITS      = 8,
  parameter int                                     CLOCKS_PER_BIT = 16,
  parameter logic [mips_debug_pkg::OPCODE_BITS-1:0] HALT_OPCODE    = 6'b111111
) (
  input  wire                                  i_clock,
  input  wire                                  i_reset,
  input  wire                                  i_rx,
  output logic                                 o_tx,
  output logic [mips_debug_pkg::WORD_BITS-1:0] o_instruction,
  output logic [ADDR_BITS-1:0]                 o_pc,
  output logic                                 o_instruction_valid,
  output logic                                 o_halted,
  output logic                                 o_step_mode
);
  import mips_debug_pkg::*;

  logic [BYTE_BITS-1:0] rx_data;
  logic                 rx_done;
  logic [BYTE_BITS-1:0] tx_data;
  logic                 tx_start;
  logic                 tx_done;
  logic                 soft_reset;
  logic                 soft_reset_ack;
  logic                 mem_write;
  logic [ADDR_BITS-1:0] mem_addr;
  logic [WORD_BITS-1:0] mem_data;
  logic [ADDR_BITS-1:0] read_addr;
  logic [WORD_BITS-1:0] read_data;
  logic                 run;
  logic                 step;

  ////////////////////
  // Serial link
  ////////////////////

  uart_rx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_uart_rx (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_rx     (i_rx),
    .o_rx_data(rx_data),
    .o_rx_done(rx_done)
  );

  uart_tx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_uart_tx (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_tx_start(tx_start),
    .i_tx_data (tx_data),
    .o_tx      (o_tx),
    .o_tx_done (tx_done)
  );

  ////////////////////
  // Loader and fetch
  ////////////////////

  debug_unit #(.ADDR_BITS(ADDR_BITS), .HALT_OPCODE(HALT_OPCODE)) u_debug_unit (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_rx_done       (rx_done),
    .i_rx_data       (rx_data),
    .i_tx_done       (tx_done),
    .i_soft_reset_ack(soft_reset_ack),
    .o_tx_start      (tx_start),
    .o_tx_data       (tx_data),
    .o_soft_reset    (soft_reset),
    .o_mem_write     (mem_write),
    .o_mem_addr      (mem_addr),
    .o_mem_data      (mem_data),
    .o_run           (run),
    .o_step_mode     (o_step_mode),
    .o_step          (step)
  );

  program_memory #(.ADDR_BITS(ADDR_BITS)) u_program_memory (
    .i_clock     (i_clock),
    .i_write     (mem_write),
    .i_write_addr(mem_addr),
    .i_write_data(mem_data),
    .i_read_addr (read_addr),
    .o_read_data (read_data)
  );

  fetch_unit #(.ADDR_BITS(ADDR_BITS), .HALT_OPCODE(HALT_OPCODE)) u_fetch_unit (
    .i_clock            (i_clock),
    .i_reset            (i_reset),
    .i_soft_reset       (soft_reset),
    .i_run              (run),
    .i_step_mode        (o_step_mode),
    .i_step             (step),
    .i_read_data        (read_data),
    .o_soft_reset_ack   (soft_reset_ack),
    .o_read_addr        (read_addr),
    .o_instruction      (o_instruction),
    .o_pc               (o_pc),
    .o_instruction_valid(o_instruction_valid),
    .o_halted           (o_halted)
  );

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
  parameter int ADDR_BITS      = 8,
  parameter int CLOCKS_PER_BIT = 16,
  parameter int NAME_CHARS     = 10
) (
  input  wire                                  i_clock,
  input  wire                                  i_reset,
  input  wire                                  i_tx,
  input  wire  [mips_debug_pkg::WORD_BITS-1:0] i_instruction,
  input  wire  [ADDR_BITS-1:0]                 i_pc,
  input  wire                                  i_instruction_valid,
  input  wire                                  i_halted,
  input  wire                                  i_step_mode,
  input  wire                                  i_test_begin,
  input  wire  [8*NAME_CHARS-1:0]              i_test_name,
  input  wire                                  i_load_word,
  input  wire  [mips_debug_pkg::WORD_BITS-1:0] i_word,
  input  wire                                  i_expect_step,
  input  wire                                  i_tx_allowed,
  input  wire                                  i_step_mark,
  input  wire                                  i_test_end,
  output int                                   o_ready_count,
  output int                                   o_strobe_count,
  output int                                   o_error_count,
  output int                                   o_tests_run,
  output int                                   o_tests_failed
);
  import mips_debug_pkg::*;

  localparam int MAX_WORDS = 2 ** ADDR_BITS;

  logic [WORD_BITS-1:0]    expected [MAX_WORDS];
  logic [8*NAME_CHARS-1:0] name = '0;
  int exp_count     = 0;
  int next_idx      = 0;
  int since_mark    = 0; // Strobes since the last step or run command.
  int test_errors   = 0;
  int strobe_errors = 0;
  int tx_errors     = 0;
  int tx_err_begin  = 0;
  int ready_total   = 0;
  int ready_begin   = 0;
  int strobe_count  = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int errors_now;

  assign o_ready_count  = ready_total - ready_begin;
  assign o_strobe_count = strobe_count;
  assign o_error_count  = strobe_errors + tx_errors;
  assign o_tests_run    = tests_run;
  assign o_tests_failed = tests_failed;

  ////////////////////
  // Instruction stream
  ////////////////////

  always @(negedge i_clock) begin
    if (i_reset) begin
      if (i_test_begin) begin
        name         = i_test_name;
        exp_count    = 0;
        next_idx     = 0;
        since_mark   = 0;
        test_errors  = 0;
        strobe_count = 0;
        tx_err_begin = tx_errors;
        ready_begin  = ready_total;
      end
      if (i_load_word) begin
        expected[exp_count] = i_word;
        exp_count++;
      end
      if (i_step_mark) begin
        since_mark = 0;
      end
      if (i_instruction_valid) begin
        if (next_idx >= exp_count) begin
          $display("Test %s: unexpected instruction strobe at pc %0d", name, i_pc);
          test_errors++;
        end else begin
          if (i_instruction != expected[next_idx]) begin
            $display("Fail %s instruction %0d: expected %h, actual %h",
                     name, next_idx, expected[next_idx], i_instruction);
            test_errors++;
          end
          if (i_pc != ADDR_BITS'(next_idx)) begin
            $display("Fail %s pc: expected %0d, actual %0d", name, next_idx, i_pc);
            test_errors++;
          end
          if (i_step_mode != i_expect_step) begin
            $display("Fail %s step mode: expected %b, actual %b",
                     name, i_expect_step, i_step_mode);
            test_errors++;
          end
          if (i_halted) begin
            $display("Test %s: halted is high while instruction %0d is delivered",
                     name, next_idx);
            test_errors++;
          end
          if (i_expect_step && since_mark != 0) begin
            $display("Test %s: more than one instruction for one step command", name);
            test_errors++;
          end
          next_idx++;
        end
        since_mark++;
        strobe_count++;
      end
      if (i_test_end) begin
        if (!i_halted) begin
          $display("Test %s: halted is still low at the end of the test", name);
          test_errors++;
        end
        if (next_idx != exp_count) begin
          $display("Test %s: only %0d of %0d instructions were delivered",
                   name, next_idx, exp_count);
          test_errors++;
        end
        errors_now = test_errors + tx_errors - tx_err_begin;
        strobe_errors += test_errors;
        tests_run++;
        if (errors_now != 0) begin
          tests_failed++;
          $display("Test %s: %0d errors", name, errors_now);
        end else begin
          $display("Test %s: ok, %0d instructions", name, next_idx);
        end
      end
    end
  end

  ////////////////////
  // Serial decoder
  ////////////////////

  initial begin : tx_decoder
    logic [BYTE_BITS-1:0] value;
    logic                 allowed;
    int                   i;
    value   = '0;
    allowed = 1'b0;
    forever begin
      @(negedge i_clock);
      if (i_reset && !i_tx) begin
        allowed = i_tx_allowed; // Frame start decides if it was expected.
        repeat (CLOCKS_PER_BIT / 2) @(negedge i_clock); // Middle of start bit.
        if (!i_tx) begin
          for (i = 0; i < BYTE_BITS; i++) begin
            repeat (CLOCKS_PER_BIT) @(negedge i_clock);
            value[i] = i_tx; // LSB first.
          end
          repeat (CLOCKS_PER_BIT) @(negedge i_clock);
          if (!i_tx) begin
            $display("Test %s: transmitted frame has a low stop bit", name);
            tx_errors++;
          end else if (!allowed) begin
            $display("Test %s: byte %h transmitted while none was expected", name, value);
            tx_errors++;
          end else if (value != CMD_READY) begin
            $display("Fail %s ready byte: expected %h, actual %h", name, CMD_READY, value);
            tx_errors++;
          end else begin
            ready_total++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_mips_debug_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_debug_top;
  import mips_debug_pkg::*;

  localparam int                     ADDR_BITS      = 8;
  localparam int                     CLOCKS_PER_BIT = 16;
  localparam logic [OPCODE_BITS-1:0] HALT_OPCODE    = 6'b111111;
  localparam int                     NAME_CHARS     = 10;
  localparam int                     NUM_TESTS      = 4;
  localparam int                     WAIT_LIMIT     = 4000; // Cycles per wait.
  localparam int                     QUIET_CYCLES   = 3 * CLOCKS_PER_BIT;
  localparam logic [31:0]            SEED           = 32'h1cce104f;

  typedef struct packed {
    logic [8*NAME_CHARS-1:0] name;
    int                      length;   // Words, halt word included.
    logic [BYTE_BITS-1:0]    run_cmd;
    int                      junk;     // Junk bytes sent first.
  } test_row_t;

  logic                 clock;
  logic                 reset;
  logic                 rx;
  logic                 tx;
  logic [WORD_BITS-1:0] instruction;
  logic [ADDR_BITS-1:0] pc;
  logic                 instruction_valid;
  logic                 halted;
  logic                 step_mode;

  logic                    test_begin;
  logic [8*NAME_CHARS-1:0] test_name;
  logic                    load_word;
  logic [WORD_BITS-1:0]    word;
  logic                    expect_step;
  logic                    tx_allowed;
  logic                    step_mark;
  logic                    test_end;
  int                      ready_count;
  int                      strobe_count;
  int                      error_count;
  int                      tests_run;
  int                      tests_failed;

  test_row_t            test_table [NUM_TESTS];
  logic [WORD_BITS-1:0] program_words [$];
  bit                   aborted;

  initial clock = 1'b0;
  always #20 clock = ~clock; // 40 ns period.

  mips_debug_top #(
    .ADDR_BITS     (ADDR_BITS),
    .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
    .HALT_OPCODE   (HALT_OPCODE)
  ) UUT (
    .i_clock            (clock),
    .i_reset            (reset),
    .i_rx               (rx),
    .o_tx               (tx),
    .o_instruction      (instruction),
    .o_pc               (pc),
    .o_instruction_valid(instruction_valid),
    .o_halted           (halted),
    .o_step_mode        (step_mode)
  );

  tb_checker #(
    .ADDR_BITS     (ADDR_BITS),
    .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
    .NAME_CHARS    (NAME_CHARS)
  ) u_checker (
    .i_clock            (clock),
    .i_reset            (reset),
    .i_tx               (tx),
    .i_instruction      (instruction),
    .i_pc               (pc),
    .i_instruction_valid(instruction_valid),
    .i_halted           (halted),
    .i_step_mode        (step_mode),
    .i_test_begin       (test_begin),
    .i_test_name        (test_name),
    .i_load_word        (load_word),
    .i_word             (word),
    .i_expect_step      (expect_step),
    .i_tx_allowed       (tx_allowed),
    .i_step_mark        (step_mark),
    .i_test_end         (test_end),
    .o_ready_count      (ready_count),
    .o_strobe_count     (strobe_count),
    .o_error_count      (error_count),
    .o_tests_run        (tests_run),
    .o_tests_failed     (tests_failed)
  );

  ////////////////////
  // Host side helpers
  ////////////////////

  task automatic next_cycle();
    @(posedge clock);
    #2; // Inputs change just after the edge.
  endtask

  task automatic idle_cycles(input int count);
    if (!aborted) begin
      repeat (count) next_cycle();
    end
  endtask

  task automatic send_byte(input logic [BYTE_BITS-1:0] value);
    int i;
    if (!aborted) begin
      rx = 1'b0; // Start bit.
      repeat (CLOCKS_PER_BIT) next_cycle();
      for (i = 0; i < BYTE_BITS; i++) begin
        rx = value[i];
        repeat (CLOCKS_PER_BIT) next_cycle();
      end
      rx = 1'b1; // Stop bit.
      repeat (CLOCKS_PER_BIT) next_cycle();
    end
  endtask

  function automatic logic [BYTE_BITS-1:0] junk_byte();
    return BYTE_BITS'($urandom_range(255, 1)); // Never a reset command.
  endfunction

  // Random words with the halt word last.
  task automatic make_program(input int length);
    logic [WORD_BITS-1:0] w;
    int                   i;
    program_words.delete();
    for (i = 0; i < length; i++) begin
      w = $urandom;
      if (i == length - 1) begin
        w[WORD_BITS-1 -: OPCODE_BITS] = HALT_OPCODE;
      end else if (w[WORD_BITS-1 -: OPCODE_BITS] == HALT_OPCODE) begin
        w[WORD_BITS-1 -: OPCODE_BITS] = ~HALT_OPCODE;
      end
      program_words.push_back(w);
    end
  endtask

  task automatic wait_ready_bytes(input int count);
    int cycles;
    cycles = 0;
    while (!aborted && ready_count < count) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timeout: the DUT did not transmit %0d ready bytes", count);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wait_strobes(input int count);
    int cycles;
    cycles = 0;
    while (!aborted && strobe_count < count) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timeout: instruction %0d was never delivered", count - 1);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wait_halted();
    int cycles;
    cycles = 0;
    while (!aborted && !halted) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timeout: the DUT never reached the halt instruction");
        aborted = 1'b1;
      end
    end
  endtask

  ////////////////////
  // One table row
  ////////////////////

  task automatic run_test(input test_row_t row);
    int i;
    int b;
    make_program(row.length);
    test_name  = row.name;
    test_begin = 1'b1;
    next_cycle();
    test_begin = 1'b0;
    tx_allowed = 1'b0;
    for (i = 0; i < row.junk; i++) begin
      send_byte(junk_byte());
    end
    idle_cycles(QUIET_CYCLES);
    tx_allowed = 1'b1;
    send_byte(CMD_RESET);
    wait_ready_bytes(3); // Ready byte repeats until answered.
    send_byte(CMD_READY);
    foreach (program_words[i]) begin
      for (b = WORD_BITS / BYTE_BITS - 1; b >= 0; b--) begin
        send_byte(program_words[i][BYTE_BITS*b +: BYTE_BITS]); // MSB first.
      end
    end
    tx_allowed = 1'b0;
    foreach (program_words[i]) begin
      load_word = 1'b1;
      word      = program_words[i];
      next_cycle();
    end
    load_word   = 1'b0;
    expect_step = (row.run_cmd == CMD_RUN_STEP);
    step_mark   = 1'b1;
    next_cycle();
    step_mark = 1'b0;
    send_byte(row.run_cmd);
    if (expect_step) begin
      wait_strobes(1);
      idle_cycles(QUIET_CYCLES);
      for (i = 1; i < row.length; i++) begin
        step_mark = 1'b1;
        next_cycle();
        step_mark = 1'b0;
        send_byte(CMD_STEP);
        wait_strobes(i + 1);
        idle_cycles(QUIET_CYCLES);
      end
    end
    wait_halted();
    idle_cycles(QUIET_CYCLES); // No strobes after the halt word.
    if (!aborted) begin
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
    end
  endtask

  initial begin : main_sequence
    int t;
    void'($urandom(SEED));
    reset       = 1'b0;
    rx          = 1'b1;
    test_begin  = 1'b0;
    test_name   = '0;
    load_word   = 1'b0;
    word        = '0;
    expect_step = 1'b0;
    tx_allowed  = 1'b0;
    step_mark   = 1'b0;
    test_end    = 1'b0;
    aborted     = 1'b0;
    test_table[0] = '{"cont_first", 5, CMD_RUN, 4};
    test_table[1] = '{"step_first", 4, CMD_RUN_STEP, 0};
    test_table[2] = '{"cont_again", 7, CMD_RUN, 2};
    test_table[3] = '{"step_again", 3, CMD_RUN_STEP, 1};
    repeat (4) next_cycle();
    reset = 1'b1;
    repeat (4) next_cycle();
    for (t = 0; t < NUM_TESTS && !aborted; t++) begin
      run_test(test_table[t]);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (aborted || error_count != 0 || tests_run != NUM_TESTS) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/mips_debug_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/debug_unit.sv
hw/program_memory.sv
hw/fetch_unit.sv
hw/mips_debug_top.sv
dv/tb_checker.sv
dv/tb_mips_debug_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --top-module tb_mips_debug_top -f build.f -o sim \
  > compile.log 2>&1 \
  && ./obj_dir/sim > sim.log 2>&1 \
  ; grep -qF '*** TEST PASSED ***' sim.log 2> /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see compile.log and sim.log"; exit 1; }
